//--- src.f
+incdir+test
rtl/ctrlPkg.sv
rtl/instrDecoder.sv
rtl/sequencer.sv
rtl/controlEncoder.sv
rtl/controlUnit.sv
test/controlUnitTb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP      = controlUnitTb
FILELIST = src.f

OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST)) test/controlTasks.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- test/controlTasks.svh
//////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////
task automatic checkCount(input integer got, input integer exp, input string what);
    numChecks++;
    if (got !== exp) begin
        numErrors++;
        $display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
endtask

task automatic checkPc(input pcCtrl_t got, input pcCtrl_t exp, input string what);
    checkCount(32'(got), 32'(exp), what);
endtask

task automatic checkCache(input cacheCtrl_t got, input cacheCtrl_t exp, input string what);
    checkCount(32'(got), 32'(exp), what);
endtask

task automatic checkAccSrc(input accSrc_t got, input accSrc_t exp, input string what);
    checkCount(32'(got), 32'(exp), what);
endtask

task automatic checkAluOp(input aluOp_t got, input aluOp_t exp, input string what);
    checkCount(32'(got), 32'(exp), what);
endtask

task automatic checkBit(input logic got, input logic exp, input string what);
    checkCount(32'(got), 32'(exp), what);
endtask

// Random memory mode 1 to 3 or immediate mode 0
function automatic logic [1:0] pickMode(input logic memForm);
    logic [1:0] mode;
    mode = 2'($unsigned($random(seed)) % 3) + 2'd1;
    return memForm ? mode : MODE_IMMED;
endfunction

task automatic waitFetch();
    int n;
    n = 0;
    while (instCacheCtrl != CACHE_READ && n < WAIT_LIMIT) begin
        @(negedge clk);
        n++;
    end
    if (instCacheCtrl != CACHE_READ) timeoutAbort("controller never returned to fetch");
endtask

//////////////////////////////////////////////////
// Instruction trace
//////////////////////////////////////////////////
task automatic traceInstr(input instr_t instr, input int stall, input logic zero);
    int waits;
    logic dataAccess;
    waits = 0;
    cycles = 0;
    accLoads = 0;
    ccLoads = 0;
    pcLoads = 0;
    dataReads = 0;
    dataWrites = 0;
    aluSrcs = 0;
    readsBefore = 0;
    seenSrc = ACC_NONE;
    @(posedge clk); // Leaving fetch0
    ir        <= instr;
    zeroFlag  <= zero;
    dataReady <= (stall == 0);
    do begin
        @(negedge clk);
        cycles++;
        dataAccess = instCacheCtrl != CACHE_READ
            && dataCacheCtrl inside {CACHE_READ, CACHE_WRITE};
        if (accLoad) begin
            accLoads++;
            seenSrc = accSrc;
        end
        if (ccLoad) ccLoads++;
        if (pcCtrl == PC_LOAD) pcLoads++;
        if (aluSrc) aluSrcs++;
        if (irLoad) begin
            checkBit(marLoad, 1'b1, "MAR load with IR load");
            checkPc(pcCtrl, PC_INC, "PC command with IR load");
        end
        if (dataAccess) begin
            waits++;
            if (dataCacheCtrl == CACHE_READ) dataReads++;
            else dataWrites++;
            if (accLoads == 0) readsBefore++;
            checkBit(indirect, instr[0], "indirect flag");
            if (waits == stall) begin
                @(posedge clk);
                dataReady <= 1'b1; // Stall over
            end
        end
    end while (instCacheCtrl != CACHE_READ && cycles < WAIT_LIMIT);
    if (instCacheCtrl != CACHE_READ) timeoutAbort("instruction never returned to fetch");
endtask

//////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////
task automatic checkResetFetch();
    @(negedge clk);
    checkPc(pcCtrl, PC_CLEAR, "PC command in start");
    checkCache(instCacheCtrl, CACHE_OFF, "instruction cache in start");
    checkCache(dataCacheCtrl, CACHE_OFF, "data cache in start");
    checkBit(accLoad | ccLoad | irLoad | marLoad | indirect | aluSrc, 1'b0, "start strobes");
    @(negedge clk);
    checkCache(instCacheCtrl, CACHE_READ, "instruction fetch");
    checkCache(dataCacheCtrl, CACHE_READ, "data cache in fetch");
    repeat (4) begin
        @(negedge clk);
        checkBit(irLoad, 1'b0, "IR load with instruction not ready");
    end
    @(posedge clk);
    instReady <= 1'b1;
    repeat (2) begin
        @(negedge clk);
        checkBit(irLoad, 1'b0, "IR load before fetch ends");
    end
    @(negedge clk);
    checkBit(irLoad, 1'b1, "IR load after ready");
    checkBit(marLoad, 1'b1, "MAR load after ready");
    checkPc(pcCtrl, PC_INC, "PC command after ready");
    waitFetch();
endtask

task automatic runAlu(input logic memForm);
    aluOp_t op;
    op = aluOp_t'($unsigned($random(seed)) % 7); // Opcodes 0 to 6
    waitFetch();
    traceInstr({1'b0, op, pickMode(memForm)}, 0, 1'b0);
    checkAluOp(aluCtrl, op, "ALU operation");
    checkCount(accLoads, 1, "ALU accumulator loads");
    checkCount(ccLoads, 1, "ALU flag loads");
    checkAccSrc(seenSrc, ACC_ALU, "ALU accumulator source");
    checkCount(aluSrcs, memForm ? 1 : 0, "ALU memory operand selects");
    checkCount(readsBefore, memForm ? 1 : 0, "ALU operand reads");
    checkCount(cycles, memForm ? 6 : 5, "ALU cycles");
endtask

task automatic runLoad(input logic memForm, input int stall);
    waitFetch();
    traceInstr({OP_LOAD, pickMode(memForm)}, stall, 1'b0);
    checkCount(accLoads, 1, "load accumulator loads");
    checkAccSrc(seenSrc, memForm ? ACC_MEM : ACC_IMMED, "load accumulator source");
    checkCount(ccLoads, 0, "load flag loads");
    checkCount(cycles, (memForm ? 6 : 5) + stall, "load cycles");
endtask

task automatic runStore(input int stall);
    waitFetch();
    traceInstr({OP_STORE, pickMode(1'b1)}, stall, 1'b0);
    checkCount(dataWrites, stall + 1, "store write cycles");
    checkCount(accLoads, 0, "store accumulator loads");
    checkCount(cycles, 4 + stall, "store cycles");
endtask

task automatic runBranch(input logic zero);
    waitFetch();
    traceInstr({OP_BRANCH, pickMode(1'b1)}, 0, zero);
    checkCount(pcLoads, zero ? 1 : 0, "branch PC loads");
    checkCount(dataReads, 1, "branch reads");
    checkCount(cycles, zero ? 6 : 5, "branch cycles");
endtask

task automatic runJump();
    waitFetch();
    traceInstr({OP_JUMP, pickMode(1'b1)}, 0, 1'b0);
    checkCount(pcLoads, 1, "jump PC loads");
    checkCount(cycles, 5, "jump cycles");
endtask

task automatic runNop(input opcode_t op);
    waitFetch();
    traceInstr({op, 2'b00}, 0, 1'b0);
    checkCount(accLoads + ccLoads + pcLoads, 0, "no-op load strobes");
    checkCount(dataReads + dataWrites, 0, "no-op data accesses");
    checkCount(cycles, 3, "no-op cycles");
endtask

//--- test/controlUnitTb.sv
`timescale 1ns/1ps

module controlUnitTb import ctrlPkg::*; ();

    localparam int WAIT_LIMIT = 40;
    localparam instr_t NOP_INSTR = 6'b100100; // Opcode 9

    logic       clk = 1'b0;
    logic       reset;
    instr_t     ir;
    logic       instReady;
    logic       dataReady;
    logic       zeroFlag;
    logic       accLoad;
    accSrc_t    accSrc;
    logic       ccLoad;
    pcCtrl_t    pcCtrl;
    logic       irLoad;
    logic       marLoad;
    logic       indirect;
    aluOp_t     aluCtrl;
    logic       aluSrc;
    cacheCtrl_t dataCacheCtrl;
    cacheCtrl_t instCacheCtrl;

    integer seed = 11;
    int numChecks = 0;
    int numErrors = 0;
    logic timedOut = 1'b0;

    // Tallies of the last traced instruction
    int cycles;
    int accLoads;
    int ccLoads;
    int pcLoads;
    int dataReads;
    int dataWrites;
    int aluSrcs;
    int readsBefore;
    accSrc_t seenSrc;

    always #4 clk = ~clk;

    controlUnit uut (
        .clk           (clk),
        .reset         (reset),
        .ir            (ir),
        .instReady     (instReady),
        .dataReady     (dataReady),
        .zeroFlag      (zeroFlag),
        .accLoad       (accLoad),
        .accSrc        (accSrc),
        .ccLoad        (ccLoad),
        .pcCtrl        (pcCtrl),
        .irLoad        (irLoad),
        .marLoad       (marLoad),
        .indirect      (indirect),
        .aluCtrl       (aluCtrl),
        .aluSrc        (aluSrc),
        .dataCacheCtrl (dataCacheCtrl),
        .instCacheCtrl (instCacheCtrl)
    );

    `include "controlTasks.svh"

    task automatic timeoutAbort(input string what);
        $display("Timeout: %s", what);
        timedOut = 1'b1;
        wait (!timedOut); // Caller stays parked until the run ends
    endtask

    initial begin
        wait (timedOut);
        $display(">>> FAIL");
        $finish;
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    initial begin
        int stall;
        reset     = 1'b1;
        ir        = NOP_INSTR;
        instReady = 1'b0;
        dataReady = 1'b1;
        zeroFlag  = 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        checkResetFetch();

        repeat (2) begin
            runAlu(1'b0);
            runAlu(1'b1);
        end
        runLoad(1'b0, 0);
        runLoad(1'b1, 0);
        stall = 1 + int'($unsigned($random(seed)) % 4);
        runLoad(1'b1, stall); // Memory form under stall
        runStore(0);
        stall = 1 + int'($unsigned($random(seed)) % 4);
        runStore(stall);
        runBranch(1'b0);
        runBranch(1'b1);
        runJump();
        runNop(4'd9);
        for (int op = 12; op < 16; op++) begin
            runNop(opcode_t'(op));
        end

        $display("Checks: %0d, errors: %0d", numChecks, numErrors);
        if (numErrors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- rtl/controlUnit.sv
`timescale 1ns/1ps

module controlUnit import ctrlPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  instr_t     ir,
    input  logic       instReady,
    input  logic       dataReady,
    input  logic       zeroFlag,
    output logic       accLoad,
    output accSrc_t    accSrc,
    output logic       ccLoad,
    output pcCtrl_t    pcCtrl,
    output logic       irLoad,
    output logic       marLoad,
    output logic       indirect,
    output aluOp_t     aluCtrl,
    output logic       aluSrc,
    output cacheCtrl_t dataCacheCtrl,
    output cacheCtrl_t instCacheCtrl
);

    instrClass_t instrClass;
    logic        immediate;
    logic        indirectMode;
    ctrlState_t  state;

    instrDecoder decoder (
        .ir           (ir),
        .instrClass   (instrClass),
        .immediate    (immediate),
        .indirectMode (indirectMode),
        .aluCtrl      (aluCtrl)
    );

    sequencer seq (
        .clk        (clk),
        .reset      (reset),
        .instrClass (instrClass),
        .immediate  (immediate),
        .instReady  (instReady),
        .dataReady  (dataReady),
        .zeroFlag   (zeroFlag),
        .state      (state)
    );

    // Control lines decoded from the current state
    controlEncoder encoder (
        .state         (state),
        .indirectMode  (indirectMode),
        .accLoad       (accLoad),
        .accSrc        (accSrc),
        .ccLoad        (ccLoad),
        .pcCtrl        (pcCtrl),
        .irLoad        (irLoad),
        .marLoad       (marLoad),
        .indirect      (indirect),
        .aluSrc        (aluSrc),
        .dataCacheCtrl (dataCacheCtrl),
        .instCacheCtrl (instCacheCtrl)
    );

endmodule

//--- rtl/controlEncoder.sv
`timescale 1ns/1ps

module controlEncoder import ctrlPkg::*; (
    input  ctrlState_t state,
    input  logic       indirectMode,
    output logic       accLoad,
    output accSrc_t    accSrc,
    output logic       ccLoad,
    output pcCtrl_t    pcCtrl,
    output logic       irLoad,
    output logic       marLoad,
    output logic       indirect,
    output logic       aluSrc,
    output cacheCtrl_t dataCacheCtrl,
    output cacheCtrl_t instCacheCtrl
);

    always_comb begin
        //////////////////////////////////////////////////
        // Idle word
        //////////////////////////////////////////////////
        accLoad       = 1'b0;
        accSrc        = ACC_NONE;
        ccLoad        = 1'b0;
        pcCtrl        = PC_HOLD;
        irLoad        = 1'b0;
        marLoad       = 1'b0;
        indirect      = 1'b0;
        aluSrc        = 1'b0;
        dataCacheCtrl = CACHE_IDLE;
        instCacheCtrl = CACHE_IDLE;

        case (state)
            stStart: begin
                pcCtrl        = PC_CLEAR;
                dataCacheCtrl = CACHE_OFF;
                instCacheCtrl = CACHE_OFF;
            end
            stFetch0: begin
                dataCacheCtrl = CACHE_READ;
                instCacheCtrl = CACHE_READ;
            end
            stFetch2: begin
                irLoad  = 1'b1;
                marLoad = 1'b1;
                pcCtrl  = PC_INC;
            end

            // Operand fetch from data memory
            stAlu1, stLoad1, stBranch0, stJump0: begin
                dataCacheCtrl = CACHE_READ;
                indirect      = indirectMode;
            end
            stStore0: begin
                dataCacheCtrl = CACHE_WRITE;
                indirect      = indirectMode;
            end

            // Accumulator writeback
            stAluImmed: begin
                accLoad = 1'b1;
                ccLoad  = 1'b1;
                accSrc  = ACC_ALU;
            end
            stAlu2: begin
                accLoad = 1'b1;
                ccLoad  = 1'b1;
                accSrc  = ACC_ALU;
                aluSrc  = 1'b1; // Operand from memory
            end
            stLoadImmed: begin
                accLoad = 1'b1;
                accSrc  = ACC_IMMED;
            end
            stLoad2: begin
                accLoad = 1'b1;
                accSrc  = ACC_MEM;
            end

            stBranch2, stJump1: pcCtrl = PC_LOAD;

            default: begin
            end
        endcase
    end

endmodule

//--- rtl/sequencer.sv
`timescale 1ns/1ps

module sequencer import ctrlPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  instrClass_t instrClass,
    input  logic        immediate,
    input  logic        instReady,
    input  logic        dataReady,
    input  logic        zeroFlag,
    output ctrlState_t  state
);

    ctrlState_t nextState;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stStart;
        end else begin
            state <= nextState;
        end
    end

    //////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////
    always_comb begin
        nextState = state; // Wait states hold by default
        case (state)
            stStart: nextState = stFetch0;

            // Fetch
            stFetch0: begin
                if (instReady) begin
                    nextState = stFetch1;
                end
            end
            stFetch1: nextState = stFetch2;
            stFetch2: begin
                case (instrClass)
                    classAlu:    nextState = stAlu0;
                    classBranch: nextState = stBranch0;
                    classJump:   nextState = stJump0;
                    classLoad:   nextState = stLoad0;
                    classStore:  nextState = stStore0;
                    default:     nextState = stFetch0;
                endcase
            end

            // ALU
            stAlu0:     nextState = immediate ? stAluImmed : stAlu1;
            stAluImmed: nextState = stFetch0;
            stAlu1: begin
                if (dataReady) begin
                    nextState = stAlu2;
                end
            end
            stAlu2: nextState = stFetch0;

            // Load
            stLoad0:     nextState = immediate ? stLoadImmed : stLoad1;
            stLoadImmed: nextState = stFetch0;
            stLoad1: begin
                if (dataReady) begin
                    nextState = stLoad2;
                end
            end
            stLoad2: nextState = stFetch0;

            stStore0: begin
                if (dataReady) begin
                    nextState = stFetch0;
                end
            end

            // Branch taken only on zero
            stBranch0: begin
                if (dataReady) begin
                    nextState = stBranch1;
                end
            end
            stBranch1: nextState = zeroFlag ? stBranch2 : stFetch0;
            stBranch2: nextState = stFetch0;

            stJump0: begin
                if (dataReady) begin
                    nextState = stJump1;
                end
            end
            stJump1: nextState = stFetch0;

            default: nextState = stStart;
        endcase
    end

endmodule

//--- rtl/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder import ctrlPkg::*; (
    input  instr_t      ir,
    output instrClass_t instrClass,
    output logic        immediate,
    output logic        indirectMode,
    output aluOp_t      aluCtrl
);

    opcode_t opcode;

    assign opcode = ir[5:2];

    // Opcodes 0 through 6 all go to the ALU
    always_comb begin
        if (opcode <= OP_ALU_LAST) begin
            instrClass = classAlu;
        end else begin
            case (opcode)
                OP_BRANCH: instrClass = classBranch;
                OP_JUMP:   instrClass = classJump;
                OP_LOAD:   instrClass = classLoad;
                OP_STORE:  instrClass = classStore;
                default:   instrClass = classNone; // 9, 12-15 fall back to fetch
            endcase
        end
    end

    assign immediate    = (ir[1:0] == MODE_IMMED);
    assign indirectMode = ir[0];

    // Low three opcode bits select the ALU function
    assign aluCtrl = ir[4:2];

endmodule

//--- rtl/ctrlPkg.sv
package ctrlPkg;

    //////////////////////////////////////////////////
    // Field widths
    //////////////////////////////////////////////////
    typedef logic [5:0] instr_t;
    typedef logic [3:0] opcode_t;
    typedef logic [2:0] aluOp_t;
    typedef logic [1:0] pcCtrl_t;
    typedef logic [1:0] cacheCtrl_t;
    typedef logic [1:0] accSrc_t;

    // Program counter commands
    localparam pcCtrl_t PC_HOLD  = 2'b00;
    localparam pcCtrl_t PC_LOAD  = 2'b01;
    localparam pcCtrl_t PC_INC   = 2'b10;
    localparam pcCtrl_t PC_CLEAR = 2'b11;

    // Memory commands for both caches
    localparam cacheCtrl_t CACHE_OFF   = 2'b00;
    localparam cacheCtrl_t CACHE_IDLE  = 2'b01;
    localparam cacheCtrl_t CACHE_READ  = 2'b10;
    localparam cacheCtrl_t CACHE_WRITE = 2'b11;

    localparam accSrc_t ACC_NONE  = 2'b00; // Don't care while accLoad low
    localparam accSrc_t ACC_MEM   = 2'b01;
    localparam accSrc_t ACC_ALU   = 2'b10;
    localparam accSrc_t ACC_IMMED = 2'b11;

    // Opcodes from instruction bits 5:2
    localparam opcode_t OP_ALU_LAST = 4'd6;
    localparam opcode_t OP_BRANCH   = 4'd7;
    localparam opcode_t OP_JUMP     = 4'd8;
    localparam opcode_t OP_LOAD     = 4'd10;
    localparam opcode_t OP_STORE    = 4'd11;

    localparam logic [1:0] MODE_IMMED = 2'b00; // Addressing mode in bits 1:0

    //////////////////////////////////////////////////
    // FSM types
    //////////////////////////////////////////////////
    typedef enum logic [2:0] {
        classAlu,
        classBranch,
        classJump,
        classLoad,
        classStore,
        classNone
    } instrClass_t;

    typedef enum logic [4:0] {
        stStart,
        stFetch0, stFetch1, stFetch2,
        stAlu0, stAluImmed, stAlu1, stAlu2,
        stLoad0, stLoadImmed, stLoad1, stLoad2,
        stStore0,
        stBranch0, stBranch1, stBranch2,
        stJump0, stJump1
    } ctrlState_t;

endpackage
